// ==== files.f ====
src/soc_pkg.sv
src/soc_bus_ctrl.sv
src/soc_memory.sv
src/soc_gpio.sv
src/soc_uart_tx.sv
src/soc_top.sv
sim/soc_checker.sv
sim/tb_soc.sv

// ==== Makefile ====
# Verilator build and run of the load/store subsystem testbench
# override on the command line, e.g. make test BUILD_DIR=out

VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= files.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN := $(BUILD_DIR)/$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_soc.sv ====
/*
  testbench for the load/store subsystem, plays the core
  - inputs change on the falling edge, responses taken on the rising edge
  - memory addresses stay inside 2**MEM_AW words
  - gpio_i follows the inverse of gpio_o one half cycle later
*/
`default_nettype none

module tb_soc;

    import soc_pkg::*;

    localparam int unsigned MEM_AW   = 10;
    localparam int unsigned GPIO_W   = 16;
    localparam int unsigned BAUD_DIV = 8;
    // 96 memory writes and 64 reads at ~3 cycles, 8 frames of 10 bits, generous margin
    localparam int TIMEOUT = 20000;

    localparam logic [31:0] GPIO_OUT = 32'h0000_8000;
    localparam logic [31:0] GPIO_ENA = 32'h0000_8004;
    localparam logic [31:0] GPIO_IN  = 32'h0000_8008;
    localparam logic [31:0] UART_DAT = 32'h0000_8040;
    localparam logic [31:0] UART_STS = 32'h0000_8044;

    logic              clk = 1'b0;
    logic              rst_n = 1'b0;
    wb_req_t           wb_req = '0;
    wb_rsp_t           wb_rsp;
    logic [GPIO_W-1:0] gpio_o;
    logic [GPIO_W-1:0] gpio_e;
    logic [GPIO_W-1:0] gpio_i = '0;
    logic              uart_txd;
    int                chk_errs;
    int                frames_left;
    int                tb_errs = 0;
    int                cycles = 0;
    logic [31:0]       rng = 32'd4;
    logic [31:0]       addrs [$];

    soc_top #(
        .MEM_AW   (MEM_AW),
        .GPIO_W   (GPIO_W),
        .BAUD_DIV (BAUD_DIV)
    ) u_soc_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .gpio_o   (gpio_o),
        .gpio_e   (gpio_e),
        .gpio_i   (gpio_i),
        .uart_txd (uart_txd)
    );

    soc_checker #(
        .GPIO_W   (GPIO_W),
        .BAUD_DIV (BAUD_DIV)
    ) u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .gpio_o      (gpio_o),
        .gpio_e      (gpio_e),
        .uart_txd    (uart_txd),
        .err_count   (chk_errs),
        .frames_left (frames_left)
    );

    always #10 clk = ~clk;

    // loopback of the pins
    always @(negedge clk) gpio_i <= ~gpio_o;

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output int waited);
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, sel: sel, dat: dat};
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!(wb_rsp.ack || wb_rsp.err));
        @(negedge clk);
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, sel: 4'hf, dat: '0};
        do begin
            @(posedge clk);
        end while (!(wb_rsp.ack || wb_rsp.err));
        dat = wb_rsp.dat;
        @(negedge clk);
        wb_req = '0;
    endtask

    // hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, a transfer or frame never finished", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        int          w;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // state right after reset
        @(negedge clk);
        if (gpio_o !== '0 || gpio_e !== '0 || uart_txd !== 1'b1 ||
            wb_rsp.ack !== 1'b0 || wb_rsp.err !== 1'b0) begin
            $display("outputs not at their reset values after reset");
            tb_errs++;
        end

        // memory, full words then byte lanes
        for (int i = 0; i < 64; i++) begin
            a = {17'b0, 13'(next_rand() & ((32'd1 << MEM_AW) - 1)), 2'b00};
            addrs.push_back(a);
            wb_write(a, next_rand(), 4'hf, w);
        end
        for (int i = 0; i < 32; i++) begin
            a = addrs[next_rand() % 64];
            d = next_rand();
            wb_write(a, next_rand(), d[3:0], w);
        end
        foreach (addrs[i]) wb_read(addrs[i], d);

        // GPIO
        wb_write(GPIO_OUT, next_rand(), 4'hf, w);
        wb_write(GPIO_ENA, next_rand(), 4'hf, w);
        wb_read(GPIO_OUT, d);
        wb_read(GPIO_ENA, d);
        repeat (4) @(posedge clk);
        wb_read(GPIO_IN, d);
        wb_write(GPIO_IN, next_rand(), 4'hf, w);
        wb_read(GPIO_OUT, d);
        wb_read(GPIO_IN, d);

        // UART, back to back writes
        wb_write(UART_DAT, next_rand(), 4'hf, w);
        wb_read(UART_STS, d);
        for (int i = 1; i < 8; i++) begin
            wb_write(UART_DAT, next_rand(), 4'hf, w);
            if (w <= int'(BAUD_DIV)) begin
                $display("uart write %0d was acked after %0d cycles, not stalled", i, w);
                tb_errs++;
            end
        end
        while (frames_left != 0) @(posedge clk);
        repeat (2 * BAUD_DIV) @(posedge clk);
        wb_read(UART_STS, d);

        // unmapped addresses, read and write
        wb_read(32'h0001_0000, d);
        wb_write(32'h0001_0000 | addrs[0], next_rand(), 4'hf, w);
        wb_read(32'h0000_800c, d);
        wb_write(32'h0000_800c, next_rand(), 4'hf, w);
        wb_read(addrs[0], d);
        wb_read(GPIO_OUT, d);
        wb_read(GPIO_ENA, d);

        repeat (4) @(posedge clk);
        $display("errors: checker %0d, testbench %0d", chk_errs, tb_errs);
        if (chk_errs + tb_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule: tb_soc

`default_nettype wire

// ==== sim/soc_checker.sv ====
/*
  bus and line checker for the load/store subsystem
  - samples the Wishbone ports on the rising edge, request held at ack
  - memory reads only of words written earlier in the run
  - UART frames sampled in the middle of each bit, 8N1
*/
`default_nettype none

module soc_checker #(
    parameter int unsigned GPIO_W   = 16,
    parameter int unsigned BAUD_DIV = 8
)(
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::wb_req_t  wb_req,
    input  soc_pkg::wb_rsp_t  wb_rsp,
    input  logic [GPIO_W-1:0] gpio_o,
    input  logic [GPIO_W-1:0] gpio_e,
    input  logic              uart_txd,
    output int                err_count,
    output int                frames_left
);

    import soc_pkg::*;

    // wait from first low sample to mid start bit
    localparam int HALF_WAIT = (BAUD_DIV / 2 > 0) ? int'(BAUD_DIV / 2) - 1 : 0;

    logic [31:0]       mem_model [int unsigned];
    logic [GPIO_W-1:0] out_model = '0;
    logic [GPIO_W-1:0] ena_model = '0;
    logic [7:0]        tx_bytes [$];
    int                pushed    = 0;
    int                popped    = 0;
    int                mon_errs  = 0;
    int                uart_errs = 0;

    assign err_count   = mon_errs + uart_errs;
    assign frames_left = pushed - popped;

    //////////////////////////////
    // reference model
    //////////////////////////////

    // {err, read data} for an address in the current model state
    function automatic logic [32:0] expect_read(input logic [31:0] adr);
        logic              err;
        logic [31:0]       dat;
        logic [GPIO_W-1:0] inv;
        err = 1'b0;
        dat = '0;
        inv = ~out_model;
        if (adr[31:16] != 16'h0) begin
            err = 1'b1;
        end else if (!adr[15]) begin
            dat = mem_model.exists(int'(adr[14:2])) ? mem_model[int'(adr[14:2])] : 'x;
        end else if (!adr[6]) begin
            case (adr[5:2])
                4'd0:    dat = 32'(out_model);
                4'd1:    dat = 32'(ena_model);
                4'd2:    dat = 32'(inv);
                default: err = 1'b1;
            endcase
        end else begin
            case (adr[5:2])
                4'd0:    dat = '0;
                // busy while any written byte is still not on the line
                4'd1:    dat = {31'b0, (pushed != popped)};
                default: err = 1'b1;
            endcase
        end
        return {err, dat};
    endfunction

    task automatic apply_write(input wb_req_t r);
        logic [31:0] word;
        if (!r.adr[15]) begin
            word = mem_model.exists(int'(r.adr[14:2])) ? mem_model[int'(r.adr[14:2])] : '0;
            for (int b = 0; b < 4; b++) begin
                if (r.sel[b]) word[8*b +: 8] = r.dat[8*b +: 8];
            end
            mem_model[int'(r.adr[14:2])] = word;
        end else if (!r.adr[6]) begin
            if (r.adr[5:2] == REG_GPIO_OUT) out_model = r.dat[GPIO_W-1:0];
            if (r.adr[5:2] == REG_GPIO_ENA) ena_model = r.dat[GPIO_W-1:0];
        end else if (r.adr[5:2] == REG_UART_DAT) begin
            tx_bytes.push_back(r.dat[7:0]);
            pushed++;
        end
    endtask

    //////////////////////////////
    // bus monitor
    //////////////////////////////

    always @(posedge clk) begin
        logic [32:0] exp;
        if (rst_n && (wb_rsp.ack || wb_rsp.err)) begin
            exp = expect_read(wb_req.adr);
            if (wb_rsp.err !== exp[32]) begin
                $display("error: wb_rsp.err adr=%h got=%h exp=%h",
                         wb_req.adr, wb_rsp.err, exp[32]);
                mon_errs++;
            end else if (wb_rsp.ack !== !exp[32]) begin
                $display("error: wb_rsp.ack adr=%h got=%h exp=%h",
                         wb_req.adr, wb_rsp.ack, !exp[32]);
                mon_errs++;
            end else if (!wb_req.we && !exp[32] && wb_rsp.dat !== exp[31:0]) begin
                $display("error: wb_rsp.dat adr=%h got=%h exp=%h",
                         wb_req.adr, wb_rsp.dat, exp[31:0]);
                mon_errs++;
            end
            if (wb_req.we && wb_rsp.ack && !exp[32]) apply_write(wb_req);
        end
        // pins and ack flop update on the same edge
        if (rst_n && gpio_o !== out_model) begin
            $display("error: gpio_o got=%h exp=%h", gpio_o, out_model);
            mon_errs++;
        end
        if (rst_n && gpio_e !== ena_model) begin
            $display("error: gpio_e got=%h exp=%h", gpio_e, ena_model);
            mon_errs++;
        end
    end

    //////////////////////////////
    // UART frame decoder
    //////////////////////////////

    initial begin
        logic [7:0] rx;
        forever begin
            @(posedge clk);
            if (rst_n && uart_txd === 1'b0) begin
                repeat (HALF_WAIT) @(posedge clk);
                if (uart_txd !== 1'b0) begin
                    $display("uart start bit too short, line went high mid bit");
                    uart_errs++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (BAUD_DIV) @(posedge clk);
                    rx[i] = uart_txd;
                end
                repeat (BAUD_DIV) @(posedge clk);
                if (uart_txd !== 1'b1) begin
                    $display("error: uart_txd stop bit got=%h exp=1", uart_txd);
                    uart_errs++;
                end
                if (popped >= pushed) begin
                    $display("uart frame %h seen without a written byte", rx);
                    uart_errs++;
                end else if (rx !== tx_bytes[popped]) begin
                    $display("error: uart_txd byte got=%h exp=%h", rx, tx_bytes[popped]);
                    uart_errs++;
                end
                popped++;
            end
        end
    end

endmodule: soc_checker

`default_nettype wire

// ==== src/soc_top.sv ====
/*
  load/store peripheral subsystem, one Wishbone manager port
  - 0x0000_0000 data memory, 0x0000_8000 GPIO, 0x0000_8040 UART
  - no added latency, the bus control block answers unmapped cycles
  - GPIO_W up to 32, MEM_AW up to 13
*/
`default_nettype none

module soc_top #(
    parameter int unsigned MEM_AW   = 10,
    parameter int unsigned GPIO_W   = 16,
    parameter int unsigned BAUD_DIV = 8
)(
    input  logic              clk,
    input  logic              rst_n,
    // manager port
    input  soc_pkg::wb_req_t  wb_req,
    output soc_pkg::wb_rsp_t  wb_rsp,
    // GPIO
    output logic [GPIO_W-1:0] gpio_o,
    output logic [GPIO_W-1:0] gpio_e,
    input  logic [GPIO_W-1:0] gpio_i,
    // UART
    output logic              uart_txd
);

    import soc_pkg::*;

    //////////////////////////////
    // internal busses
    //////////////////////////////

    wb_req_t mem_req;
    wb_rsp_t mem_rsp;
    wb_req_t gpio_req;
    wb_rsp_t gpio_rsp;
    wb_req_t uart_req;
    wb_rsp_t uart_rsp;

    // decode and merge
    soc_bus_ctrl u_bus_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (wb_req),
        .rsp      (wb_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .gpio_req (gpio_req),
        .gpio_rsp (gpio_rsp),
        .uart_req (uart_req),
        .uart_rsp (uart_rsp)
    );

    //////////////////////////////
    // targets
    //////////////////////////////

    // data memory
    soc_memory #(
        .MEM_AW (MEM_AW)
    ) u_memory (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

    // GPIO controller
    soc_gpio #(
        .GPIO_W (GPIO_W)
    ) u_gpio (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (gpio_req),
        .rsp    (gpio_rsp),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i)
    );

    // UART transmitter
    soc_uart_tx #(
        .BAUD_DIV (BAUD_DIV)
    ) u_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (uart_req),
        .rsp      (uart_rsp),
        .uart_txd (uart_txd)
    );

endmodule: soc_top

`default_nettype wire

// ==== src/soc_uart_tx.sv ====
/*
  UART transmitter, 8N1, BAUD_DIV clocks per bit (at least 1)
  - data write while idle is acked at once, start bit follows the ack cycle
  - data write while busy stalls ack until the frame ends
  - status bit 0 is busy, data register reads return zero
*/
`default_nettype none

module soc_uart_tx #(
    parameter int unsigned BAUD_DIV = 8
)(
    input  logic             clk,
    input  logic             rst_n,
    input  soc_pkg::wb_req_t req,
    output soc_pkg::wb_rsp_t rsp,
    output logic             uart_txd
);

    import soc_pkg::*;

    localparam int unsigned CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    soc_adr_t   adr;
    logic       access;
    logic       wr_dat;
    logic       stall;
    logic       load;
    logic       ack_q;
    logic [31:0] rdat_q;
    // frame state
    logic       busy_q;
    logic       run_q;
    logic [9:0] shift_q;
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0] bit_cnt;

    assign adr    = req.adr;
    assign access = req.cyc & req.stb & ~ack_q;
    assign wr_dat = req.we && (adr.per.idx == REG_UART_DAT);

    // back-pressure while a frame is pending or on the line
    assign stall = access & wr_dat & busy_q;
    assign load  = access & wr_dat & ~busy_q;

    //////////////////////////////
    // bus side
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access & ~stall;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !req.we) begin
            rdat_q <= (adr.per.idx == REG_UART_STS) ? {31'b0, busy_q} : '0;
        end
    end

    assign rsp = '{ack: ack_q, err: 1'b0, dat: rdat_q};

    //////////////////////////////
    // line side
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            run_q    <= 1'b0;
            shift_q  <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            uart_txd <= 1'b1;
        end else if (load) begin
            // stop, data LSB first, start
            shift_q <= {1'b1, req.dat[7:0], 1'b0};
            busy_q  <= 1'b1;
        end else if (busy_q && !run_q) begin
            // cycle after ack, start bit goes out
            run_q    <= 1'b1;
            uart_txd <= shift_q[0];
            shift_q  <= {1'b1, shift_q[9:1]};
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (run_q) begin
            if (baud_cnt == CNT_W'(BAUD_DIV - 1)) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    // stop bit done, line stays high
                    run_q  <= 1'b0;
                    busy_q <= 1'b0;
                end else begin
                    bit_cnt  <= bit_cnt + 4'd1;
                    uart_txd <= shift_q[0];
                    shift_q  <= {1'b1, shift_q[9:1]};
                end
            end else begin
                baud_cnt <= baud_cnt + CNT_W'(1);
            end
        end
    end

    // manager keeps a stalled write unchanged until it is acked
    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req.cyc && req.stb && stall) |=> (req.cyc && req.stb && $stable(req)));

endmodule: soc_uart_tx

`default_nettype wire

// ==== src/soc_gpio.sv ====
/*
  GPIO controller with output, enable and input registers
  - GPIO_W must be 32 or less, reads are zero-extended
  - byte lanes are ignored, every write is a full register write
  - the input register is read-only, writes to it are acked and dropped
*/
`default_nettype none

module soc_gpio #(
    parameter int unsigned GPIO_W = 16
)(
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::wb_req_t  req,
    output soc_pkg::wb_rsp_t  rsp,
    // pins
    output logic [GPIO_W-1:0] gpio_o,
    output logic [GPIO_W-1:0] gpio_e,
    input  logic [GPIO_W-1:0] gpio_i
);

    import soc_pkg::*;

    soc_adr_t          adr;
    logic              access;
    logic              ack_q;
    logic [31:0]       rdat_q;
    logic [GPIO_W-1:0] in_meta_q;
    logic [GPIO_W-1:0] in_sync_q;

    assign adr    = req.adr;
    assign access = req.cyc & req.stb & ~ack_q;

    // two-flop input synchronizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_i;
            in_sync_q <= in_meta_q;
        end
    end

    // ack and register writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q  <= 1'b0;
            gpio_o <= '0;
            gpio_e <= '0;
        end else begin
            ack_q <= access;
            if (access && req.we) begin
                case (adr.per.idx)
                    REG_GPIO_OUT: gpio_o <= req.dat[GPIO_W-1:0];
                    REG_GPIO_ENA: gpio_e <= req.dat[GPIO_W-1:0];
                    default:      ;
                endcase
            end
        end
    end

    // read data, registered with ack
    always_ff @(posedge clk) begin
        if (access && !req.we) begin
            case (adr.per.idx)
                REG_GPIO_OUT: rdat_q <= 32'(gpio_o);
                REG_GPIO_ENA: rdat_q <= 32'(gpio_e);
                REG_GPIO_IN:  rdat_q <= 32'(in_sync_q);
                default:      rdat_q <= '0;
            endcase
        end
    end

    assign rsp = '{ack: ack_q, err: 1'b0, dat: rdat_q};

endmodule: soc_gpio

`default_nettype wire

// ==== src/soc_memory.sv ====
/*
  single-port data memory, 2**MEM_AW words of 32 bits
  - byte lanes written per sel, reads return the full word
  - ack one clock after stb, read data registered with it
  - MEM_AW must not exceed 13, contents are undefined after reset
*/
`default_nettype none

module soc_memory #(
    parameter int unsigned MEM_AW = 10
)(
    input  logic             clk,
    input  logic             rst_n,
    input  soc_pkg::wb_req_t req,
    output soc_pkg::wb_rsp_t rsp
);

    import soc_pkg::*;

    localparam int unsigned DEPTH = 2**MEM_AW;

    // word index field is only 13 bits wide
    if (MEM_AW > 13) begin: gen_aw_check
        $error("soc_memory: MEM_AW larger than the 13-bit word index");
    end: gen_aw_check

    soc_adr_t          adr;
    logic [MEM_AW-1:0] widx;
    logic              access;
    logic              ack_q;
    logic [31:0]       rdat_q;
    logic [31:0]       mem_q [DEPTH];

    assign adr  = req.adr;
    assign widx = adr.mem.widx[MEM_AW-1:0];

    // first cycle of a transfer only
    assign access = req.cyc & req.stb & ~ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // byte lane writes
    always_ff @(posedge clk) begin
        if (access && req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req.sel[b]) begin
                    mem_q[widx][8*b +: 8] <= req.dat[8*b +: 8];
                end
            end
        end
    end

    // full word read
    always_ff @(posedge clk) begin
        if (access && !req.we) begin
            rdat_q <= mem_q[widx];
        end
    end

    assign rsp = '{ack: ack_q, err: 1'b0, dat: rdat_q};

    // accesses past the array would alias
    a_widx_range: assert property (@(posedge clk) disable iff (!rst_n)
        (req.cyc && req.stb) |-> (int'(adr.mem.widx) < int'(DEPTH)));

endmodule: soc_memory

`default_nettype wire

// ==== src/soc_bus_ctrl.sv ====
/*
  address decoder and response merge for one Wishbone manager
  - only one target is selected at a time, so acks are simply ORed
  - unmapped addresses get a registered err one clock after stb
  - the manager must hold the request until ack or err
*/
`default_nettype none

module soc_bus_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    // manager side
    input  soc_pkg::wb_req_t req,
    output soc_pkg::wb_rsp_t rsp,
    // target side
    output soc_pkg::wb_req_t mem_req,
    input  soc_pkg::wb_rsp_t mem_rsp,
    output soc_pkg::wb_req_t gpio_req,
    input  soc_pkg::wb_rsp_t gpio_rsp,
    output soc_pkg::wb_req_t uart_req,
    input  soc_pkg::wb_rsp_t uart_rsp
);

    import soc_pkg::*;

    //////////////////////////////
    // decoding
    //////////////////////////////

    soc_adr_t adr;
    logic     upper_ok;
    logic     sel_mem;
    logic     sel_gpio;
    logic     sel_uart;
    logic     sel_err;
    logic     err_q;

    assign adr = req.adr;

    // upper field is shared by both views
    assign upper_ok = (adr.mem.upper == '0);

    // memory view
    assign sel_mem  = upper_ok && (adr.mem.region == REGION_MEM);

    // peripheral view, register index checked per peripheral
    assign sel_gpio = upper_ok && (adr.per.region == REGION_PER)
                    && (adr.per.psel == PSEL_GPIO) && (adr.per.idx <= REG_GPIO_IN);
    assign sel_uart = upper_ok && (adr.per.region == REGION_PER)
                    && (adr.per.psel == PSEL_UART) && (adr.per.idx <= REG_UART_STS);

    // nothing matched
    assign sel_err  = !(sel_mem || sel_gpio || sel_uart);

    //////////////////////////////
    // request forwarding
    //////////////////////////////

    // each target sees stb only when addressed
    always_comb begin
        mem_req      = req;
        mem_req.stb  = req.stb & sel_mem;
        gpio_req     = req;
        gpio_req.stb = req.stb & sel_gpio;
        uart_req     = req;
        uart_req.stb = req.stb & sel_uart;
    end

    // error pulse, one per held stb
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req.cyc & req.stb & sel_err & ~err_q;
        end
    end

    //////////////////////////////
    // response merge
    //////////////////////////////

    always_comb begin
        rsp.ack = mem_rsp.ack | gpio_rsp.ack | uart_rsp.ack;
        rsp.err = err_q | mem_rsp.err | gpio_rsp.err | uart_rsp.err;
        // request is still held at ack time, so the select is valid
        if (sel_mem) begin
            rsp.dat = mem_rsp.dat;
        end else if (sel_gpio) begin
            rsp.dat = gpio_rsp.dat;
        end else if (sel_uart) begin
            rsp.dat = uart_rsp.dat;
        end else begin
            rsp.dat = '0;
        end
    end

    // targets and the error path never answer together
    a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rsp.ack && rsp.err));

    // any answer belongs to a pending request
    a_rsp_pending: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.ack || rsp.err) |-> (req.cyc && req.stb));

endmodule: soc_bus_ctrl

`default_nettype wire

// ==== src/soc_pkg.sv ====
/*
  shared bus types and address map of the load/store subsystem
  - Wishbone classic, 32-bit data, byte addresses, 4 byte lanes
  - bits 31:16 of every mapped address must be zero
  - bit 15 splits memory from peripherals, bit 6 splits GPIO from UART
*/
`default_nettype none

package soc_pkg;

    //////////////////////////////
    // Wishbone bus
    //////////////////////////////

    // request, driven by the manager
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;  // byte address
        logic [3:0]  sel;  // byte lanes
        logic [31:0] dat;  // write data
    } wb_req_t;

    // response, driven by a target
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;  // read data
    } wb_rsp_t;

    //////////////////////////////
    // address decoding
    //////////////////////////////

    // memory view of an address
    typedef struct packed {
        logic [15:0] upper;   // must be zero
        logic        region;
        logic [12:0] widx;    // word index
        logic [1:0]  boff;    // byte offset
    } soc_mem_adr_t;

    // peripheral view of the same address
    typedef struct packed {
        logic [15:0] upper;   // must be zero
        logic        region;
        logic [7:0]  spare;
        logic        psel;    // bit 6
        logic [3:0]  idx;     // register index
        logic [1:0]  boff;
    } soc_per_adr_t;

    typedef union packed {
        soc_mem_adr_t mem;
        soc_per_adr_t per;
    } soc_adr_t;

    // region bit and peripheral select values
    localparam logic REGION_MEM = 1'b0;
    localparam logic REGION_PER = 1'b1;
    localparam logic PSEL_GPIO  = 1'b0;
    localparam logic PSEL_UART  = 1'b1;

    // GPIO register indices
    localparam logic [3:0] REG_GPIO_OUT = 4'd0;
    localparam logic [3:0] REG_GPIO_ENA = 4'd1;
    localparam logic [3:0] REG_GPIO_IN  = 4'd2;

    // UART register indices
    localparam logic [3:0] REG_UART_DAT = 4'd0;
    localparam logic [3:0] REG_UART_STS = 4'd1;

endpackage: soc_pkg

`default_nettype wire
